/* source/cu_pkg.sv */
/*
 * Compute unit edge-data package
 * Data and cache line sizes, address masks, and the structs for
 * commands, responses, edge jobs, the work descriptor and buffer status
 */
`default_nettype none

package cu_pkg;

	// Vertex data word and cache line sizes in bytes
	parameter int DATA_SIZE_READ  = 4;
	parameter int CACHELINE_BYTES = 64;

	// Line boundary and byte-in-line masks
	parameter logic [63:0] ADDRESS_ALIGN_MASK = 64'hFFFF_FFFF_FFFF_FFC0;
	parameter logic [63:0] OFFSET_MASK        = 64'h0000_0000_0000_003F;

	// Read kind, chosen by configuration bit 13
	typedef enum logic {
		READ_CL_NA = 1'b0,
		READ_CL_S  = 1'b1
	} command_kind_t;

	// Arbitration and translation mode
	typedef enum logic [2:0] {
		ABT_STRICT = 3'b000,
		ABT_ABORT  = 3'b001,
		ABT_PAGE   = 3'b010,
		ABT_PREF   = 3'b011,
		ABT_SPEC   = 3'b111
	} abt_t;

	typedef struct packed {
		logic        valid;
		logic [63:0] base_address;
	} wed_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] src;
		logic [31:0] dest;
	} edge_job_t;

	typedef struct packed {
		logic          valid;
		logic [63:0]   address;
		logic [7:0]    size;
		command_kind_t kind;
		abt_t          abt;
		logic [3:0]    offset;
		logic [7:0]    cu_id;
		logic [31:0]   tag;
	} command_t;

	// Offset and tag come back as sent
	typedef struct packed {
		logic         valid;
		logic [3:0]   offset;
		logic [31:0]  tag;
		logic [511:0] line;
	} response_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] dest;
		logic [31:0] data;
	} edge_data_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic empty;
		logic valid;
	} buffer_status_t;

	// Configuration bits 10 to 12 to abt, unknown codes fall back to strict
	function automatic abt_t map_abt(input logic [2:0] bits);
		abt_t mode;
		case (bits)
			3'b001:  mode = ABT_ABORT;
			3'b010:  mode = ABT_PAGE;
			3'b011:  mode = ABT_PREF;
			3'b111:  mode = ABT_SPEC;
			default: mode = ABT_STRICT;
		endcase
		return mode;
	endfunction

endpackage

`default_nettype wire

/* source/cu_fifo.sv */
/*
 * Synchronous FIFO for any packed payload
 * Registered output that is cleared when idle, so the payload
 * valid bit strobes once per pop
 */
`timescale 1ns/10ps
`default_nettype none

module cu_fifo import cu_pkg::*; #(
	parameter type payload_t    = logic,
	parameter int  BUFFER_DEPTH = 16
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           push,
	input  payload_t       data_in,
	input  logic           pop,
	output payload_t       data_out,
	output buffer_status_t status
);

	localparam int PTR_W = $clog2(BUFFER_DEPTH);

	payload_t         mem [BUFFER_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             empty;
	logic             do_push;
	logic             do_pop;
	logic             valid_q;

	assign full    = (count == (PTR_W+1)'(BUFFER_DEPTH));
	assign empty   = (count == '0);
	// Push on full and pop on empty are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Almost full two entries below depth
	assign status = '{
		full:   full,
		alfull: (count >= (PTR_W+1)'(BUFFER_DEPTH - 2)),
		empty:  empty,
		valid:  valid_q
	};

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Pointers wrap naturally at power-of-two depth
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			valid_q  <= 1'b0;
			data_out <= '0;
		end else begin
			valid_q <= do_pop;
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr   <= rd_ptr + 1'b1;
				data_out <= mem[rd_ptr];
			end else begin
				data_out <= '0;
			end
			count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
		end
	end

endmodule

`default_nettype wire

/* source/cu_edge_job_input.sv */
/*
 * Edge job intake
 * Latches jobs from upstream, queues them and keeps the
 * upstream request level up while there is room
 */
`timescale 1ns/10ps
`default_nettype none

module cu_edge_job_input import cu_pkg::*; #(
	parameter int BUFFER_DEPTH = 16
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  edge_job_t      edge_job,
	input  logic           job_pop,
	output logic           edge_request,
	output edge_job_t      job_out,
	output buffer_status_t job_status
);

	edge_job_t job_latched;

	// Input latch, nothing taken while disabled
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_latched <= '0;
		end else if (enabled) begin
			job_latched <= edge_job;
		end else begin
			job_latched.valid <= 1'b0;
		end
	end

	// Two-entry margin covers jobs already in flight
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_request <= 1'b0;
		end else begin
			edge_request <= !job_status.alfull;
		end
	end

	cu_fifo #(
		.payload_t   (edge_job_t),
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_latched.valid),
		.data_in (job_latched),
		.pop     (job_pop),
		.data_out(job_out),
		.status  (job_status)
	);

endmodule

`default_nettype wire

/* source/cu_edge_data_control.sv */
/*
 * Edge data command control
 * Owns enable, configuration and descriptor latches, turns each
 * edge job into a cache line read for its destination vertex and
 * queues the commands toward memory
 */
`timescale 1ns/10ps
`default_nettype none

module cu_edge_data_control import cu_pkg::*; #(
	parameter int CU_ID        = 1,
	parameter int BUFFER_DEPTH = 16
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled_in,
	input  logic [63:0]    cu_configure,
	input  wed_t           wed_request,
	input  edge_job_t      job_out,
	input  buffer_status_t job_status,
	input  buffer_status_t read_buffer_status,
	output logic           job_pop,
	output logic           enabled,
	output command_t       read_command
);

	logic [63:0]    cu_configure_latched;
	wed_t           wed_latched;
	command_t       command_latched;
	buffer_status_t cmd_status;
	logic           cmd_pop;
	logic [63:0]    dest_bytes;
	logic [63:0]    offset_bytes;

	////////////////////////////////////////////////////////////
	// Enable, configuration and descriptor
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	// All-zero configuration word keeps the previous one
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_configure_latched <= '0;
			wed_latched          <= '0;
		end else if (enabled) begin
			wed_latched <= wed_request;
			if (|cu_configure) begin
				cu_configure_latched <= cu_configure;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Command build
	////////////////////////////////////////////////////////////

	// Byte distance of the dest word from the base
	assign dest_bytes   = 64'(job_out.dest) << $clog2(DATA_SIZE_READ);
	assign offset_bytes = dest_bytes & OFFSET_MASK;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_latched <= '0;
		end else if (enabled && job_out.valid && wed_latched.valid) begin
			command_latched.valid   <= 1'b1;
			// Whole line fetched, word picked out on return
			command_latched.address <= (wed_latched.base_address + dest_bytes)
				& ADDRESS_ALIGN_MASK;
			command_latched.size    <= 8'(CACHELINE_BYTES);
			command_latched.offset  <= 4'(offset_bytes >> $clog2(DATA_SIZE_READ));
			command_latched.abt     <= map_abt(cu_configure_latched[12:10]);
			command_latched.cu_id   <= 8'(CU_ID);
			command_latched.tag     <= job_out.dest;
			if (cu_configure_latched[13]) begin
				command_latched.kind <= READ_CL_S;
			end else begin
				command_latched.kind <= READ_CL_NA;
			end
		end else begin
			command_latched.valid <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Flow control and command queue
	////////////////////////////////////////////////////////////

	// Hold jobs once the command queue nears full
	assign job_pop = !job_status.empty && !cmd_status.alfull;
	// External queue almost full stops issue
	assign cmd_pop = !cmd_status.empty && !read_buffer_status.alfull;

	cu_fifo #(
		.payload_t   (command_t),
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (command_latched.valid),
		.data_in (command_latched),
		.pop     (cmd_pop),
		.data_out(read_command),
		.status  (cmd_status)
	);

endmodule

`default_nettype wire

/* source/cu_edge_data_output.sv */
/*
 * Edge data output
 * Picks the vertex word out of each returned cache line and
 * buffers it with its dest until downstream asks for it
 */
`timescale 1ns/10ps
`default_nettype none

module cu_edge_data_output import cu_pkg::*; #(
	parameter int BUFFER_DEPTH = 16
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  response_t      read_response,
	input  logic           edge_data_request,
	output edge_data_t     edge_data,
	output buffer_status_t data_buffer_status
);

	response_t  response_latched;
	edge_data_t edge_data_word;
	logic       request_latched;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_latched <= '0;
		end else if (enabled) begin
			response_latched <= read_response;
		end else begin
			response_latched.valid <= 1'b0;
		end
	end

	// Word 0 sits in the low bits of the line
	assign edge_data_word = '{
		valid: response_latched.valid,
		dest:  response_latched.tag,
		data:  response_latched.line[32*response_latched.offset +: 32]
	};

	// Downstream request, registered and masked by empty
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			request_latched <= 1'b0;
		end else begin
			request_latched <= edge_data_request && !data_buffer_status.empty;
		end
	end

	cu_fifo #(
		.payload_t   (edge_data_t),
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) data_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (edge_data_word.valid),
		.data_in (edge_data_word),
		.pop     (request_latched),
		.data_out(edge_data),
		.status  (data_buffer_status)
	);

endmodule

`default_nettype wire

/* source/cu_edge_data_top.sv */
/*
 * Compute unit edge data path
 * Job intake, read command control and data output joined
 */
`timescale 1ns/10ps
`default_nettype none

module cu_edge_data_top import cu_pkg::*; #(
	parameter int CU_ID        = 1,
	parameter int BUFFER_DEPTH = 16
) (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled_in,
	input  logic [63:0]    cu_configure,
	input  wed_t           wed_request,
	input  edge_job_t      edge_job,
	output logic           edge_request,
	output command_t       read_command,
	input  buffer_status_t read_buffer_status,
	input  response_t      read_response,
	input  logic           edge_data_request,
	output edge_data_t     edge_data,
	output buffer_status_t data_buffer_status
);

	logic           enabled;
	logic           job_pop;
	edge_job_t      job_out;
	buffer_status_t job_status;

	cu_edge_job_input #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) job_input (
		.clock       (clock),
		.rstn        (rstn),
		.enabled     (enabled),
		.edge_job    (edge_job),
		.job_pop     (job_pop),
		.edge_request(edge_request),
		.job_out     (job_out),
		.job_status  (job_status)
	);

	cu_edge_data_control #(
		.CU_ID       (CU_ID),
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) data_control (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.cu_configure      (cu_configure),
		.wed_request       (wed_request),
		.job_out           (job_out),
		.job_status        (job_status),
		.read_buffer_status(read_buffer_status),
		.job_pop           (job_pop),
		.enabled           (enabled),
		.read_command      (read_command)
	);

	cu_edge_data_output #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) data_output (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.read_response     (read_response),
		.edge_data_request (edge_data_request),
		.edge_data         (edge_data),
		.data_buffer_status(data_buffer_status)
	);

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
/*
 * Testbench clock and reset
 * 4 ns clock, active low reset held for the first 8 cycles
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD       = 4.0,
	parameter int  RESET_CYCLES = 8
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2.0) clock = ~clock;
	end

	// Release 1 ns after the last reset edge, same as other stimulus
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rstn = 1'b1;
	end

endmodule

`default_nettype wire

/* verif/tb_cu_edge_data.sv */
/*
 * Edge data path testbench
 * Directed tests with a cache line memory model behind the
 * read command port and a checker on both output streams
 */
`timescale 1ns/10ps
`default_nettype none

module tb_cu_edge_data import cu_pkg::*;;

	localparam int CU_ID          = 5;
	localparam int BUFFER_DEPTH   = 4;
	// Jobs over all tests set the run limit
	localparam int JOBS_TOTAL     = 27;
	localparam int TIMEOUT_CYCLES = 40 * JOBS_TOTAL + 200;

	logic           clock;
	logic           rstn;
	logic           enabled_in;
	logic [63:0]    cu_configure;
	wed_t           wed_request;
	edge_job_t      edge_job;
	logic           edge_request;
	command_t       read_command;
	buffer_status_t read_buffer_status;
	response_t      read_response;
	logic           edge_data_request;
	edge_data_t     edge_data;
	buffer_status_t data_buffer_status;

	int          errors = 0;
	int          cycle = 0;
	int          last_due = 0;
	int          commands_checked = 0;
	int          data_checked = 0;
	logic [63:0] base;
	logic [63:0] cfg;
	abt_t        cfg_abt;

	// Observed and expected streams
	command_t   cmd_seen [$];
	command_t   exp_cmd_q [$];
	edge_data_t data_seen [$];
	edge_data_t exp_data_q [$];
	// Memory model backlog with answer cycles
	command_t   mem_q [$];
	int         due_q [$];

	tb_clock_gen #(
		.PERIOD      (4.0),
		.RESET_CYCLES(8)
	) clock_gen (
		.clock(clock),
		.rstn (rstn)
	);

	cu_edge_data_top #(
		.CU_ID       (CU_ID),
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) dut (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.cu_configure      (cu_configure),
		.wed_request       (wed_request),
		.edge_job          (edge_job),
		.edge_request      (edge_request),
		.read_command      (read_command),
		.read_buffer_status(read_buffer_status),
		.read_response     (read_response),
		.edge_data_request (edge_data_request),
		.edge_data         (edge_data),
		.data_buffer_status(data_buffer_status)
	);

	////////////////////////////////////////////////////////////
	// Memory model and monitors
	////////////////////////////////////////////////////////////

	// Word i of the line at line_addr
	function automatic logic [31:0] line_word(input logic [63:0] line_addr, input int index);
		logic [63:0] v;
		v = line_addr + 64'(4 * index) + 64'h1000_0000;
		return v[31:0];
	endfunction

	// Outputs sampled mid-cycle away from the driving edge
	always @(negedge clock) begin : monitor
		int due;
		if (rstn && read_command.valid) begin
			cmd_seen.push_back(read_command);
			mem_q.push_back(read_command);
			// Answers 2 to 6 cycles out and in command order
			due = cycle + 2 + int'($urandom % 5);
			if (due <= last_due) begin
				due = last_due + 1;
			end
			last_due = due;
			due_q.push_back(due);
		end
		if (rstn && edge_data.valid) begin
			data_seen.push_back(edge_data);
		end
	end

	initial begin : memory_model
		command_t  c;
		response_t r;
		read_response = '0;
		forever begin
			@(posedge clock);
			#1;
			if (mem_q.size() > 0 && due_q[0] <= cycle) begin
				c = mem_q.pop_front();
				due_q.delete(0);
				r.valid  = 1'b1;
				r.offset = c.offset;
				r.tag    = c.tag;
				for (int i = 0; i < 16; i++) begin
					r.line[32*i +: 32] = line_word(c.address, i);
				end
				read_response = r;
			end else begin
				read_response = '0;
			end
		end
	end

	// Cycle count and run limit
	always @(posedge clock) begin
		cycle = cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("Timeout: test still running after %0d cycles, %0d errors so far",
				cycle, errors);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and stimulus helpers
	////////////////////////////////////////////////////////////

	task automatic check_command(input command_t got, input command_t exp, input string what);
		commands_checked++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s: addr %h off %0d kind %0d abt %0d cu %0d tag %h size %0d",
				$time, what, got.address, got.offset, got.kind, got.abt, got.cu_id,
				got.tag, got.size);
			$display("     expected addr %h off %0d kind %0d abt %0d cu %0d tag %h size %0d",
				exp.address, exp.offset, exp.kind, exp.abt, exp.cu_id, exp.tag, exp.size);
		end
	endtask

	task automatic check_edge_data(input edge_data_t got, input edge_data_t exp,
		input string what);
		data_checked++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s: dest %h data %h, expected dest %h data %h",
				$time, what, got.dest, got.data, exp.dest, exp.data);
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Every drive lands 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	// Command per the address, offset and config rules
	function automatic command_t expected_command(input logic [31:0] dest);
		command_t c;
		c.valid   = 1'b1;
		c.address = (base + {30'b0, dest, 2'b00}) & ~64'h3F;
		c.size    = 8'(CACHELINE_BYTES);
		c.kind    = cfg[13] ? READ_CL_S : READ_CL_NA;
		c.abt     = cfg_abt;
		c.offset  = dest[3:0];
		c.cu_id   = 8'(CU_ID);
		c.tag     = dest;
		return c;
	endfunction

	// One job once the upstream request level is up
	task automatic send_job(input logic [31:0] dest);
		while (!edge_request) begin
			next_cycle();
		end
		edge_job = '{valid: 1'b1, src: ~dest, dest: dest};
		next_cycle();
		edge_job = '0;
		next_cycle();
	endtask

	task automatic queue_job(input logic [31:0] dest);
		command_t   c;
		edge_data_t d;
		c = expected_command(dest);
		d = '{valid: 1'b1, dest: dest, data: line_word(c.address, int'(c.offset))};
		exp_cmd_q.push_back(c);
		exp_data_q.push_back(d);
		send_job(dest);
	endtask

	// Zero word leaves the model config as it was
	task automatic set_config(input logic [63:0] word, input abt_t abt);
		cu_configure = word;
		if (word != '0) begin
			cfg     = word;
			cfg_abt = abt;
		end
		repeat (3) next_cycle();
	endtask

	// Drain both streams against the expected queues
	task automatic expect_results(input string what);
		int n;
		n = exp_cmd_q.size();
		while (cmd_seen.size() < n || data_seen.size() < n) begin
			next_cycle();
		end
		repeat (n) begin
			check_command(cmd_seen.pop_front(), exp_cmd_q.pop_front(), what);
			check_edge_data(data_seen.pop_front(), exp_data_q.pop_front(), what);
		end
		repeat (8) next_cycle();
		check_level(cmd_seen.size() == 0 && data_seen.size() == 0, 1'b1,
			{what, ": no extra commands or data"});
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		repeat (3) begin
			@(negedge clock);
			check_level(edge_request, 1'b0, "edge_request in reset");
			check_level(read_command.valid, 1'b0, "read_command.valid in reset");
			check_level(edge_data.valid, 1'b0, "edge_data.valid in reset");
			check_level(data_buffer_status.empty, 1'b1, "data buffer empty in reset");
		end
		@(posedge rstn);
		@(negedge clock);
		check_level(edge_request, 1'b0, "edge_request after reset");
		check_level(read_command.valid, 1'b0, "read_command.valid after reset");
		check_level(edge_data.valid, 1'b0, "edge_data.valid after reset");
		check_level(data_buffer_status.empty, 1'b1, "data buffer empty after reset");
		next_cycle();
	endtask

	task automatic test_command_build();
		// Bit 13 set and abt code 3'b011
		set_config(64'h0000_0000_0000_2C05, ABT_PREF);
		queue_job(32'h0001_234B);
		expect_results("command build");
	endtask

	task automatic test_config_latch();
		set_config(64'h0000_0000_0000_0401, ABT_ABORT);
		queue_job(32'd7);
		expect_results("config change");
		set_config(64'h0, ABT_STRICT);
		queue_job(32'd40);
		expect_results("zero config ignored");
	endtask

	task automatic test_data_extraction();
		logic [31:0] dests [4];
		dests = '{32'd0, 32'd15, 32'd16, 32'h3FFF_FFFF};
		foreach (dests[i]) begin
			queue_job(dests[i]);
		end
		// Random dests from the seeded stream
		repeat (4) begin
			queue_job($urandom & 32'h00FF_FFFF);
		end
		expect_results("data extraction");
	endtask

	task automatic test_back_pressure();
		read_buffer_status.alfull = 1'b1;
		read_buffer_status.empty  = 1'b0;
		fork
			begin
				for (int i = 0; i < 12; i++) begin
					queue_job(32'h200 + 32'(3 * i));
				end
			end
			begin
				// Queues fill until upstream is held off
				while (edge_request) begin
					next_cycle();
				end
				repeat (10) next_cycle();
				check_level(cmd_seen.size() == 0, 1'b1,
					"no command while external queue almost full");
				read_buffer_status.alfull = 1'b0;
				read_buffer_status.empty  = 1'b1;
			end
		join
		expect_results("back-pressure release");
	endtask

	task automatic test_enable_gate();
		enabled_in = 1'b0;
		repeat (3) next_cycle();
		for (int i = 0; i < 4; i++) begin
			send_job(32'h50 + 32'(i));
		end
		repeat (30) next_cycle();
		check_level(cmd_seen.size() == 0, 1'b1, "no command while disabled");
		check_level(data_seen.size() == 0, 1'b1, "no data while disabled");
	endtask

	initial begin
		void'($urandom(32'h2016));
		enabled_in         = 1'b0;
		cu_configure       = '0;
		wed_request        = '0;
		edge_job           = '0;
		read_buffer_status = '{full: 1'b0, alfull: 1'b0, empty: 1'b1, valid: 1'b0};
		edge_data_request  = 1'b0;
		// Line aligned base above 4 GB
		base               = 64'h0000_0001_0004_0000;
		cfg                = '0;
		cfg_abt            = ABT_STRICT;

		test_reset_state();
		enabled_in        = 1'b1;
		wed_request       = '{valid: 1'b1, base_address: base};
		edge_data_request = 1'b1;

		test_command_build();
		test_config_latch();
		test_data_extraction();
		test_back_pressure();
		test_enable_gate();

		$display("Errors: %0d, commands checked %0d, data words checked %0d",
			errors, commands_checked, data_checked);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* cu_edge_data_top.f */
source/cu_pkg.sv
source/cu_fifo.sv
source/cu_edge_job_input.sv
source/cu_edge_data_control.sv
source/cu_edge_data_output.sv
source/cu_edge_data_top.sv
verif/tb_clock_gen.sv
verif/tb_cu_edge_data.sv

/* Makefile */
# Verilator flow for the compute unit edge data path

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module cu_edge_data_top -f cu_edge_data_top.f

sim:
	verilator --binary --timing -j 0 --top-module tb_cu_edge_data \
		-f cu_edge_data_top.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
